// ==== Bender.yml ====
package:
  name: cache

sources:
  - verilog/cache_cfg_pkg.sv
  - verilog/cache_regs_pkg.sv
  - verilog/cache_ifs.sv
  - verilog/cache_memory.sv
  - verilog/cache_back_end.sv
  - verilog/cache_control.sv
  - verilog/cache_top.sv
  - target: test
    files:
      - verif/cache_tb.sv

// ==== files.f ====
verilog/cache_cfg_pkg.sv
verilog/cache_regs_pkg.sv
verilog/cache_ifs.sv
verilog/cache_memory.sv
verilog/cache_back_end.sv
verilog/cache_control.sv
verilog/cache_top.sv
verif/cache_tb.sv

// ==== verif/cache_cases.txt ====
# op addr data strb flag (hex): R front-end read, W front-end write, A APB read,
# P APB write, M memory model word; flag is the expected pslverr_o
R 0040 10102010 0 0
R 0040 10102010 0 0
A 04 00000001 0 0
A 08 00000001 0 0
W 0044 CAFEF00D F 0
R 0044 CAFEF00D 0 0
M 0044 CAFEF00D 0 0
A 0C 00000001 0 0
W 0200 AABBCCDD 5 0
M 0200 80BB90DD 0 0
R 0200 80BB90DD 0 0
A 10 00000001 0 0
A 08 00000002 0 0
P 14 00000001 0 0
R 0044 CAFEF00D 0 0
A 08 00000003 0 0
A 04 00000002 0 0
A 00 00000001 0 0
P 14 00000002 0 0
A 04 00000000 0 0
A 08 00000000 0 0
A 0C 00000000 0 0
A 10 00000000 0 0
A 18 00000000 0 1
A 14 00000000 0 1
R 0300 C0C0D0C0 0 0
R 030C C3C3D3C3 0 0
R 0100 40405040 0 0
R 0300 C0C0D0C0 0 0
A 08 00000003 0 0
A 04 00000001 0 0

// ==== verif/cache_tb.sv ====
/* cache testbench: clock, reset, memory model, front-end and APB drivers,
   compare tasks, stall monitor and watchdog, driven from the cases file */

`timescale 1ns/100ps
`default_nettype none

module cache_tb;
   import cache_cfg_pkg::*;
   import cache_regs_pkg::*;

   logic      clk_i;
   logic      rst_n_i;
   logic      req_i;
   logic      we_i;
   addr_t     addr_i;
   word_t     wdata_i;
   strb_t     wstrb_i;
   word_t     rdata_o;
   logic      ack_o;
   logic      mem_req_o;
   logic      mem_we_o;
   addr_t     mem_addr_o;
   word_t     mem_wdata_o;
   strb_t     mem_wstrb_o;
   word_t     mem_rdata_i;
   logic      mem_ack_i;
   logic      psel_i;
   logic      penable_i;
   logic      pwrite_i;
   reg_addr_t paddr_i;
   word_t     pwdata_i;
   word_t     prdata_o;
   logic      pready_o;
   logic      pslverr_o;

   // memory model state
   word_t       mem [256];
   logic        mem_busy;
   int unsigned lat_cnt;
   int          seed;

   // parsed cases
   byte   op_q[$];
   addr_t addr_q[$];
   word_t data_q[$];
   strb_t strb_q[$];
   logic  flag_q[$];
   int    n_cases;
   bit    loaded;

   int n_checks;
   int n_errors;

   // stall monitor state
   logic  stalled_q;
   addr_t held_addr;
   word_t held_wdata;

   cache_top dut_i (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .req_i      (req_i),
      .we_i       (we_i),
      .addr_i     (addr_i),
      .wdata_i    (wdata_i),
      .wstrb_i    (wstrb_i),
      .rdata_o    (rdata_o),
      .ack_o      (ack_o),
      .mem_req_o  (mem_req_o),
      .mem_we_o   (mem_we_o),
      .mem_addr_o (mem_addr_o),
      .mem_wdata_o(mem_wdata_o),
      .mem_wstrb_o(mem_wstrb_o),
      .mem_rdata_i(mem_rdata_i),
      .mem_ack_i  (mem_ack_i),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .paddr_i    (paddr_i),
      .pwdata_i   (pwdata_i),
      .prdata_o   (prdata_o),
      .pready_o   (pready_o),
      .pslverr_o  (pslverr_o)
   );

   always #4 clk_i = ~clk_i;

   task automatic check_word(input string name, input word_t got, input word_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // word-wide memory acked after 0 to 3 idle cycles
   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         mem_ack_i <= 1'b0;
         mem_busy  <= 1'b0;
         lat_cnt   <= 0;
      end else if (mem_ack_i) begin
         mem_ack_i <= 1'b0;
         mem_busy  <= 1'b0;
      end else if (mem_busy) begin
         if (lat_cnt == 0) begin
            mem_ack_i   <= 1'b1;
            mem_rdata_i <= mem[mem_addr_o[9:2]];
            if (mem_we_o) begin
               for (int b = 0; b < NBYTES; b++) begin
                  if (mem_wstrb_o[b]) begin
                     mem[mem_addr_o[9:2]][8*b +: 8] = mem_wdata_o[8*b +: 8];
                  end
               end
            end
         end else begin
            lat_cnt <= lat_cnt - 1;
         end
      end else if (mem_req_o) begin
         mem_busy <= 1'b1;
         lat_cnt  <= $unsigned($random(seed)) % 4;
      end
   end

   // request fields must hold while the memory stalls
   always @(negedge clk_i) begin
      if (rst_n_i && stalled_q) begin
         check_addr("mem_addr_o", mem_addr_o, held_addr);
         check_word("mem_wdata_o", mem_wdata_o, held_wdata);
      end
      stalled_q  = rst_n_i && mem_req_o && !mem_ack_i;
      held_addr  = mem_addr_o;
      held_wdata = mem_wdata_o;
   end

   task automatic fe_access(input logic we, input addr_t a, input word_t d, input strb_t s,
                            output word_t rd);
      @(posedge clk_i);
      req_i   <= 1'b1;
      we_i    <= we;
      addr_i  <= a;
      wdata_i <= d;
      wstrb_i <= s;
      @(negedge clk_i);
      while (ack_o !== 1'b1) @(negedge clk_i);
      rd = rdata_o;
      // no memory transfer left once the access is acknowledged
      check_flag("mem_req_o", mem_req_o, 1'b0);
      @(posedge clk_i);
      req_i <= 1'b0;
      // ack_o is a single-cycle pulse
      @(negedge clk_i);
      check_flag("ack_o", ack_o, 1'b0);
   endtask

   task automatic apb_transfer(input logic wr, input reg_addr_t a, input word_t d,
                               output word_t rd, output logic err);
      @(posedge clk_i);
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      pwrite_i  <= wr;
      paddr_i   <= a;
      pwdata_i  <= d;
      @(posedge clk_i);
      penable_i <= 1'b1;
      // no wait states in the access phase
      @(negedge clk_i);
      check_flag("pready_o", pready_o, 1'b1);
      rd  = prdata_o;
      err = pslverr_o;
      @(posedge clk_i);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
   endtask

   // cases file columns op addr data strb flag in hex
   task automatic load_cases(output bit ok);
      int          fd;
      int          code;
      int          op_c;
      int unsigned a, d, s, f;
      string       skip;
      fd = $fopen("verif/cache_cases.txt", "r");
      ok = (fd != 0);
      while (ok && !$feof(fd)) begin
         code = $fscanf(fd, " %c", op_c);
         if (code != 1) break;
         if (op_c == "#") begin
            code = $fgets(skip, fd);
         end else begin
            code = $fscanf(fd, "%h %h %h %h", a, d, s, f);
            op_q.push_back(byte'(op_c));
            addr_q.push_back(addr_t'(a));
            data_q.push_back(word_t'(d));
            strb_q.push_back(strb_t'(s));
            flag_q.push_back(f[0]);
         end
      end
      if (ok) $fclose(fd);
      n_cases = op_q.size();
   endtask

   task automatic run_case(input int i);
      word_t rd;
      logic  err;
      int    errs_before;
      errs_before = n_errors;
      case (op_q[i])
         "R": begin
            fe_access(1'b0, addr_q[i], '0, '0, rd);
            check_word("rdata_o", rd, data_q[i]);
         end
         "W": fe_access(1'b1, addr_q[i], data_q[i], strb_q[i], rd);
         "A": begin
            apb_transfer(1'b0, reg_addr_t'(addr_q[i]), '0, rd, err);
            check_word("prdata_o", rd, data_q[i]);
            check_flag("pslverr_o", err, flag_q[i]);
         end
         "P": begin
            apb_transfer(1'b1, reg_addr_t'(addr_q[i]), data_q[i], rd, err);
            check_flag("pslverr_o", err, flag_q[i]);
         end
         // memory model contents after a write-through
         "M": check_word("memory word", mem[addr_q[i][9:2]], data_q[i]);
         default: begin
            n_errors++;
            $display("case %0d has an unknown operation code", i);
         end
      endcase
      $display("case %0d: %c %h %s", i, op_q[i], addr_q[i],
               (n_errors == errs_before) ? "ok" : "FAILED");
   endtask

   initial begin
      wait (loaded);
      repeat (n_cases * 200 + 1000) @(posedge clk_i);
      $display("timeout: the cases did not finish within %0d cycles", n_cases * 200 + 1000);
      $display("Checks failed");
      $finish;
   end

   initial begin
      bit ok;
      clk_i       = 1'b0;
      rst_n_i     = 1'b0;
      req_i       = 1'b0;
      we_i        = 1'b0;
      addr_i      = '0;
      wdata_i     = '0;
      wstrb_i     = '0;
      mem_rdata_i = '0;
      mem_ack_i   = 1'b0;
      psel_i      = 1'b0;
      penable_i   = 1'b0;
      pwrite_i    = 1'b0;
      paddr_i     = '0;
      pwdata_i    = '0;
      seed        = 57601;
      n_checks    = 0;
      n_errors    = 0;
      stalled_q   = 1'b0;
      for (int n = 0; n < 256; n++) begin
         mem[n] = word_t'(n) * 32'h0101_0101 + 32'h1000;
      end
      load_cases(ok);
      if (!ok) begin
         $display("could not open verif/cache_cases.txt");
         $display("Checks failed");
         $finish;
      end else begin
         loaded = 1'b1;
         repeat (5) @(posedge clk_i);
         rst_n_i <= 1'b1;
         for (int i = 0; i < n_cases; i++) begin
            run_case(i);
         end
         $display("%0d cases, %0d checks, %0d errors", n_cases, n_checks, n_errors);
         if (n_errors == 0) begin
            $display("All checks passed");
         end else begin
            $display("Checks failed");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/cache_back_end.sv ====
/* back-end sequencer: line refills as word beats and single-word
   write-throughs onto the memory port */

`timescale 1ns/100ps
`default_nettype none

module cache_back_end #(
   parameter int NLINES_W      = 4,
   parameter int WORD_OFFSET_W = 2
) (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   cache_refill_if.be_mp        refill,
   output logic                 mem_req_o,
   output logic                 mem_we_o,
   output cache_cfg_pkg::addr_t mem_addr_o,
   output cache_cfg_pkg::word_t mem_wdata_o,
   output cache_cfg_pkg::strb_t mem_wstrb_o,
   input  cache_cfg_pkg::word_t mem_rdata_i,
   input  logic                 mem_ack_i
);
   import cache_cfg_pkg::*;

   localparam int BYTE_OFF_W = $clog2(NBYTES);
   localparam int TAG_W      = ADDR_W - BYTE_OFF_W - WORD_OFFSET_W - NLINES_W;

   typedef enum logic [1:0] {BE_IDLE, BE_READ, BE_WRITE} be_state_t;

   be_state_t                state_q;
   logic [WORD_OFFSET_W-1:0] beat_q;
   logic                     last_beat;
   logic [TAG_W-1:0]         line_tag;
   logic [NLINES_W-1:0]      line_idx;

   assign {line_tag, line_idx} = refill.refill_line_addr;
   assign last_beat            = (beat_q == '1);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= BE_IDLE;
         beat_q  <= '0;
      end else begin
         case (state_q)
            BE_IDLE: begin
               beat_q <= '0;
               if (refill.refill_req) begin
                  state_q <= BE_READ;
               end else if (refill.wt_req) begin
                  state_q <= BE_WRITE;
               end
            end
            BE_READ: begin
               if (mem_ack_i) begin
                  beat_q <= beat_q + WORD_OFFSET_W'(1);
                  if (last_beat) begin
                     state_q <= BE_IDLE;
                  end
               end
            end
            BE_WRITE: begin
               if (mem_ack_i) begin
                  state_q <= BE_IDLE;
               end
            end
            default: state_q <= BE_IDLE;
         endcase
      end
   end

   assign mem_req_o   = (state_q != BE_IDLE);
   assign mem_we_o    = (state_q == BE_WRITE);
   // word aligned in both cases
   assign mem_addr_o  = (state_q == BE_WRITE) ?
                        {refill.wt_addr[ADDR_W-1:BYTE_OFF_W], BYTE_OFF_W'(0)} :
                        {line_tag, line_idx, beat_q, BYTE_OFF_W'(0)};
   assign mem_wdata_o = refill.wt_data;
   assign mem_wstrb_o = (state_q == BE_WRITE) ? refill.wt_strb : '0;

   // each acknowledged beat goes straight to the data array
   assign refill.refill_valid    = (state_q == BE_READ) && mem_ack_i;
   assign refill.refill_word_idx = beat_q;
   assign refill.refill_data     = mem_rdata_i;
   assign refill.refill_done     = refill.refill_valid && last_beat;
   assign refill.wt_done         = (state_q == BE_WRITE) && mem_ack_i;
   assign refill.be_idle         = (state_q == BE_IDLE);

   addr_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (mem_req_o && !mem_ack_i) |=> $stable(mem_addr_o))
      else $error("mem_addr_o changed during a stalled request");

endmodule

`default_nettype wire

// ==== verilog/cache_cfg_pkg.sv ====
/* cache geometry constants and the address, word and strobe types
   shared by the datapath blocks */

`default_nettype none

package cache_cfg_pkg;

   // front-end byte address width
   localparam int ADDR_W = 16;

   // word width and bytes per word
   localparam int DATA_W = 32;
   localparam int NBYTES = DATA_W / 8;

   // byte address
   typedef logic [ADDR_W-1:0] addr_t;

   // data word
   typedef logic [DATA_W-1:0] word_t;

   // one strobe bit per byte lane
   typedef logic [NBYTES-1:0] strb_t;

endpackage

`default_nettype wire

// ==== verilog/cache_control.sv ====
/* APB slave with saturating hit/miss counters, back-end status
   and the invalidate and counter-clear commands */

`timescale 1ns/100ps
`default_nettype none

module cache_control (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      psel_i,
   input  logic                      penable_i,
   input  logic                      pwrite_i,
   input  cache_regs_pkg::reg_addr_t paddr_i,
   input  cache_cfg_pkg::word_t      pwdata_i,
   output cache_cfg_pkg::word_t      prdata_o,
   output logic                      pready_o,
   output logic                      pslverr_o,
   cache_event_if.sink_mp            events,
   input  logic                      be_idle_i
);
   import cache_cfg_pkg::*;
   import cache_regs_pkg::*;

   // rd_hit, rd_miss, wr_hit, wr_miss in register order
   word_t      cnt_q [4];
   logic [3:0] ev;
   logic       access;
   logic       ctrl_wr;
   logic       cnt_clear;
   logic       mapped;

   assign access    = psel_i && penable_i;
   assign ev        = {events.wr_miss, events.wr_hit, events.rd_miss, events.rd_hit};
   assign ctrl_wr   = access && pwrite_i && (paddr_i == REG_CTRL);
   assign cnt_clear = ctrl_wr && pwdata_i[CTRL_CLEAR_BIT];

   // valid bits drop at the end of the access phase
   assign events.invalidate = ctrl_wr && pwdata_i[CTRL_INVALIDATE_BIT];

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < 4; i++) begin
            cnt_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (cnt_clear) begin
               cnt_q[i] <= '0;
            end else if (ev[i] && cnt_q[i] != '1) begin
               cnt_q[i] <= cnt_q[i] + 32'd1;
            end
         end
      end
   end

   always_comb begin
      prdata_o = '0;
      mapped   = 1'b1;
      case (paddr_i)
         REG_STATUS:    prdata_o = word_t'(be_idle_i);
         REG_RD_HITS:   prdata_o = cnt_q[0];
         REG_RD_MISSES: prdata_o = cnt_q[1];
         REG_WR_HITS:   prdata_o = cnt_q[2];
         REG_WR_MISSES: prdata_o = cnt_q[3];
         // command register cannot be read back
         REG_CTRL:      mapped = pwrite_i;
         default:       mapped = 1'b0;
      endcase
   end

   // no wait states
   assign pready_o  = access;
   assign pslverr_o = access && !mapped;

   apb_enable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      penable_i |-> psel_i)
      else $error("penable_i high without psel_i");

endmodule

`default_nettype wire

// ==== verilog/cache_ifs.sv ====
/* refill/write-through channel between cache memory and back-end,
   and the hit/miss event and invalidate channel */

`timescale 1ns/100ps
`default_nettype none

interface cache_refill_if #(
   parameter int WORD_OFFSET_W = 2
) ();
   import cache_cfg_pkg::*;

   // line address is the byte address without word and byte offsets
   localparam int LINE_ADDR_W = ADDR_W - $clog2(NBYTES) - WORD_OFFSET_W;

   logic                     refill_req;
   logic [LINE_ADDR_W-1:0]   refill_line_addr;
   logic                     wt_req;
   addr_t                    wt_addr;
   word_t                    wt_data;
   strb_t                    wt_strb;
   logic                     refill_valid;
   logic [WORD_OFFSET_W-1:0] refill_word_idx;
   word_t                    refill_data;
   logic                     refill_done;
   logic                     wt_done;
   logic                     be_idle;

   modport mem_mp (
      output refill_req, refill_line_addr, wt_req, wt_addr, wt_data, wt_strb,
      input  refill_valid, refill_word_idx, refill_data, refill_done, wt_done, be_idle
   );

   modport be_mp (
      input  refill_req, refill_line_addr, wt_req, wt_addr, wt_data, wt_strb,
      output refill_valid, refill_word_idx, refill_data, refill_done, wt_done, be_idle
   );

endinterface

interface cache_event_if ();
   logic rd_hit;
   logic rd_miss;
   logic wr_hit;
   logic wr_miss;
   logic invalidate;

   modport src_mp (output rd_hit, rd_miss, wr_hit, wr_miss, input invalidate);
   modport sink_mp (input rd_hit, rd_miss, wr_hit, wr_miss, output invalidate);

endinterface

`default_nettype wire

// ==== verilog/cache_memory.sv ====
/* direct-mapped tag, valid and data arrays with hit detection,
   front-end request register and the lookup/refill/write FSM */

`timescale 1ns/100ps
`default_nettype none

module cache_memory #(
   parameter int NLINES_W      = 4,
   parameter int WORD_OFFSET_W = 2
) (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 req_i,
   input  logic                 we_i,
   input  cache_cfg_pkg::addr_t addr_i,
   input  cache_cfg_pkg::word_t wdata_i,
   input  cache_cfg_pkg::strb_t wstrb_i,
   output cache_cfg_pkg::word_t rdata_o,
   output logic                 ack_o,
   cache_refill_if.mem_mp       refill,
   cache_event_if.src_mp        events
);
   import cache_cfg_pkg::*;

   localparam int BYTE_OFF_W = $clog2(NBYTES);
   localparam int TAG_W      = ADDR_W - BYTE_OFF_W - WORD_OFFSET_W - NLINES_W;
   localparam int NLINES     = 2 ** NLINES_W;
   localparam int NWORDS     = NLINES * (2 ** WORD_OFFSET_W);

   typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, WRITE} state_t;

   state_t state_q;
   logic   ack_q;
   logic   accept;
   logic   hit;

   // registered front-end request
   logic  we_q;
   addr_t addr_q;
   word_t wdata_q;
   strb_t wstrb_q;
   word_t rdata_q;

   logic [TAG_W-1:0]         addr_tag;
   logic [NLINES_W-1:0]      addr_idx;
   logic [WORD_OFFSET_W-1:0] addr_off;

   logic [NLINES-1:0] valid_q;
   logic [TAG_W-1:0]  tag_mem [NLINES];
   word_t             data_mem [NWORDS];

   assign {addr_tag, addr_idx, addr_off} = addr_q[ADDR_W-1:BYTE_OFF_W];

   // no new request while the previous ack is still visible
   assign accept = (state_q == IDLE) && req_i && !ack_q;
   assign hit    = valid_q[addr_idx] && (tag_mem[addr_idx] == addr_tag);

   always_ff @(posedge clk_i) begin
      if (accept) begin
         we_q    <= we_i;
         addr_q  <= addr_i;
         wdata_q <= wdata_i;
         wstrb_q <= wstrb_i;
      end
      if (state_q == LOOKUP && hit) begin
         if (!we_q) begin
            rdata_q <= data_mem[{addr_idx, addr_off}];
         end else begin
            // byte merge of the write hit
            for (int b = 0; b < NBYTES; b++) begin
               if (wstrb_q[b]) begin
                  data_mem[{addr_idx, addr_off}][8*b +: 8] <= wdata_q[8*b +: 8];
               end
            end
         end
      end
      if (refill.refill_valid) begin
         data_mem[{addr_idx, refill.refill_word_idx}] <= refill.refill_data;
         if (refill.refill_word_idx == addr_off) begin
            rdata_q <= refill.refill_data;
         end
      end
      if (refill.refill_done) begin
         tag_mem[addr_idx] <= addr_tag;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         ack_q   <= 1'b0;
         valid_q <= '0;
      end else begin
         ack_q <= 1'b0;
         if (events.invalidate) begin
            valid_q <= '0;
         end
         case (state_q)
            IDLE: begin
               if (accept) begin
                  state_q <= LOOKUP;
               end
            end
            LOOKUP: begin
               if (we_q) begin
                  state_q <= WRITE;
               end else if (hit) begin
                  ack_q   <= 1'b1;
                  state_q <= IDLE;
               end else begin
                  state_q <= REFILL;
               end
            end
            REFILL: begin
               if (refill.refill_done) begin
                  valid_q[addr_idx] <= 1'b1;
                  ack_q             <= 1'b1;
                  state_q           <= IDLE;
               end
            end
            WRITE: begin
               if (refill.wt_done) begin
                  ack_q   <= 1'b1;
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   assign rdata_o = rdata_q;
   assign ack_o   = ack_q;

   // requests to the back-end, held until the matching done
   assign refill.refill_req       = (state_q == REFILL);
   assign refill.refill_line_addr = {addr_tag, addr_idx};
   assign refill.wt_req           = (state_q == WRITE);
   assign refill.wt_addr          = addr_q;
   assign refill.wt_data          = wdata_q;
   assign refill.wt_strb          = wstrb_q;

   // lookup lasts one cycle, so these are single pulses
   assign events.rd_hit  = (state_q == LOOKUP) && !we_q && hit;
   assign events.rd_miss = (state_q == LOOKUP) && !we_q && !hit;
   assign events.wr_hit  = (state_q == LOOKUP) && we_q && hit;
   assign events.wr_miss = (state_q == LOOKUP) && we_q && !hit;

   req_held_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (req_i && !ack_o) |=> req_i)
      else $error("req_i dropped before ack_o");

endmodule

`default_nettype wire

// ==== verilog/cache_regs_pkg.sv ====
/* APB register map of the cache control block and the command bits of REG_CTRL */

`default_nettype none

package cache_regs_pkg;

   localparam int REG_ADDR_W = 5;

   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // register offsets, byte addressed
   localparam reg_addr_t REG_STATUS    = 5'h00;
   localparam reg_addr_t REG_RD_HITS   = 5'h04;
   localparam reg_addr_t REG_RD_MISSES = 5'h08;
   localparam reg_addr_t REG_WR_HITS   = 5'h0C;
   localparam reg_addr_t REG_WR_MISSES = 5'h10;
   // write only
   localparam reg_addr_t REG_CTRL      = 5'h14;

   // command bits in REG_CTRL
   localparam int CTRL_INVALIDATE_BIT = 0;
   localparam int CTRL_CLEAR_BIT      = 1;

endpackage

`default_nettype wire

// ==== verilog/cache_top.sv ====
/* cache top level: cache memory, back-end and APB control block */

`timescale 1ns/100ps
`default_nettype none

module cache_top #(
   parameter int NLINES_W      = 4,
   parameter int WORD_OFFSET_W = 2
) (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   // front-end
   input  logic                      req_i,
   input  logic                      we_i,
   input  cache_cfg_pkg::addr_t      addr_i,
   input  cache_cfg_pkg::word_t      wdata_i,
   input  cache_cfg_pkg::strb_t      wstrb_i,
   output cache_cfg_pkg::word_t      rdata_o,
   output logic                      ack_o,
   // memory port
   output logic                      mem_req_o,
   output logic                      mem_we_o,
   output cache_cfg_pkg::addr_t      mem_addr_o,
   output cache_cfg_pkg::word_t      mem_wdata_o,
   output cache_cfg_pkg::strb_t      mem_wstrb_o,
   input  cache_cfg_pkg::word_t      mem_rdata_i,
   input  logic                      mem_ack_i,
   // APB
   input  logic                      psel_i,
   input  logic                      penable_i,
   input  logic                      pwrite_i,
   input  cache_regs_pkg::reg_addr_t paddr_i,
   input  cache_cfg_pkg::word_t      pwdata_i,
   output cache_cfg_pkg::word_t      prdata_o,
   output logic                      pready_o,
   output logic                      pslverr_o
);

   cache_refill_if #(.WORD_OFFSET_W(WORD_OFFSET_W)) refill_if ();
   cache_event_if event_if ();

   cache_memory #(
      .NLINES_W     (NLINES_W),
      .WORD_OFFSET_W(WORD_OFFSET_W)
   ) cache_memory_i (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .req_i  (req_i),
      .we_i   (we_i),
      .addr_i (addr_i),
      .wdata_i(wdata_i),
      .wstrb_i(wstrb_i),
      .rdata_o(rdata_o),
      .ack_o  (ack_o),
      .refill (refill_if.mem_mp),
      .events (event_if.src_mp)
   );

   cache_back_end #(
      .NLINES_W     (NLINES_W),
      .WORD_OFFSET_W(WORD_OFFSET_W)
   ) cache_back_end_i (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .refill     (refill_if.be_mp),
      .mem_req_o  (mem_req_o),
      .mem_we_o   (mem_we_o),
      .mem_addr_o (mem_addr_o),
      .mem_wdata_o(mem_wdata_o),
      .mem_wstrb_o(mem_wstrb_o),
      .mem_rdata_i(mem_rdata_i),
      .mem_ack_i  (mem_ack_i)
   );

   cache_control cache_control_i (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .psel_i   (psel_i),
      .penable_i(penable_i),
      .pwrite_i (pwrite_i),
      .paddr_i  (paddr_i),
      .pwdata_i (pwdata_i),
      .prdata_o (prdata_o),
      .pready_o (pready_o),
      .pslverr_o(pslverr_o),
      .events   (event_if.sink_mp),
      .be_idle_i(refill_if.be_idle)
   );

endmodule

`default_nettype wire
